//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_educell_predecoder
FILELIST  ?= educell_predecoder.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
EXE       := V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(EXE)

run: compile
	./$(BUILD_DIR)/$(EXE) 2>&1 | tee $(LOG)
	@grep -qx "sim passed" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- educell_predecoder.f
+incdir+hdl
hdl/cell_geometry_pkg.sv
hdl/patch_config_pkg.sv
hdl/educell_region_decoder.sv
hdl/educell_role_decoder.sv
hdl/educell_stabilizer_decoder.sv
hdl/educell_config_latch.sv
hdl/educell_predecoder.sv
tests/educell_checker.sv
tests/tb_educell_predecoder.sv

//--- hdl/cell_geometry_pkg.sv
`include "educell_params.svh"

package cell_geometry_pkg;

    // Position of the cell inside its patch
    typedef enum logic [3:0]
    {
        NW,
        N,
        NE,
        W,
        E,
        SW,
        S,
        SE,
        C
    } region_t;

    // Couplable directions, MSB first: nw, ne, sw, se, n, s
    typedef logic [`DIR_BW-1:0] dir_set_t;

endpackage

//--- hdl/educell_config_latch.sv
`timescale 1ns/1ps
`include "educell_params.svh"

module educell_config_latch
    import cell_geometry_pkg::*;
    import patch_config_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     req,
    output logic     ack,
    input  role_t    dec_role,
    input  dir_set_t dec_possible_dir,
    input  pauli_t   dec_syn_to_west,
    input  pauli_t   dec_syn_to_east,
    input  logic     dec_first_aqmeas_flag,
    output role_t    role,
    output dir_set_t possible_dir,
    output pauli_t   syn_to_west,
    output pauli_t   syn_to_east,
    output logic     first_aqmeas_flag
);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ack <= 1'b0;
            role <= `ROLE_INACTIVE;
            possible_dir <= '0;
            syn_to_west <= '0;
            syn_to_east <= '0;
            first_aqmeas_flag <= 1'b0;
        end
        else if (req && !ack)
        begin
            ack <= 1'b1;                    // Capture edge
            role <= dec_role;
            possible_dir <= dec_possible_dir;
            syn_to_west <= dec_syn_to_west;
            syn_to_east <= dec_syn_to_east;
            first_aqmeas_flag <= dec_first_aqmeas_flag;
        end
        else if (!req && ack)
        begin
            ack <= 1'b0;                    // Return to idle
        end
    end

endmodule

//--- hdl/educell_params.svh
`ifndef EDUCELL_PARAMS_SVH
`define EDUCELL_PARAMS_SVH

// Field widths
`define PCHTYPE_BW      4
`define FACEBD_BW       2
`define LOCATION_BW     7
`define DIR_BW          6
`define PCHINFO_BW      (`PCHTYPE_BW + 4 * `FACEBD_BW)

// Patch types still decoded
`define PCHTYPE_ZT      4'd1
`define PCHTYPE_ZB      4'd2

// Face boundary kinds
`define FACEBD_NONE     2'd0
`define FACEBD_PP       2'd1
`define FACEBD_MP       2'd2
`define FACEBD_LP       2'd3

`define ROLE_INACTIVE   2'd0
`define ROLE_ACTIVE     2'd1
`define ROLE_BOUNDARY   2'd2

// Pauli operator of a syndrome edge
`define PP_I            2'd0
`define PP_X            2'd1
`define PP_Z            2'd2

`endif

//--- hdl/educell_predecoder.sv
`timescale 1ns/1ps
`include "educell_params.svh"

module educell_predecoder
    import cell_geometry_pkg::*;
    import patch_config_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`LOCATION_BW-1:0] location,
    input  logic [`PCHINFO_BW-1:0]  pchinfo,
    input  logic                    req,
    output logic                    ack,
    output role_t                   role,
    output dir_set_t                possible_dir,
    output pauli_t                  syn_to_west,
    output pauli_t                  syn_to_east,
    output logic                    first_aqmeas_flag
);

    region_t  region;
    logic     even;
    pchtype_t pchtype;
    facebd_t  facebd_e;
    role_t    dec_role;
    dir_set_t dec_possible_dir;
    pauli_t   dec_syn_to_west;
    pauli_t   dec_syn_to_east;
    logic     dec_first_aqmeas_flag;

    // pchinfo is {type, west, north, east, south}, only type and east are read
    assign pchtype = pchinfo[`PCHINFO_BW-1 -: `PCHTYPE_BW];
    assign facebd_e = pchinfo[2*`FACEBD_BW-1 -: `FACEBD_BW];

    educell_region_decoder region_decoder_inst
    (
        .location (location),
        .region   (region),
        .even     (even)
    );

    educell_role_decoder role_decoder_inst
    (
        .region       (region),
        .even         (even),
        .pchtype      (pchtype),
        .facebd_e     (facebd_e),
        .role         (dec_role),
        .possible_dir (dec_possible_dir)
    );

    educell_stabilizer_decoder stabilizer_decoder_inst
    (
        .region            (region),
        .even              (even),
        .pchtype           (pchtype),
        .facebd_e          (facebd_e),
        .syn_to_west       (dec_syn_to_west),
        .syn_to_east       (dec_syn_to_east),
        .first_aqmeas_flag (dec_first_aqmeas_flag)
    );

    educell_config_latch config_latch_inst
    (
        .clk                   (clk),
        .reset                 (reset),
        .req                   (req),
        .ack                   (ack),
        .dec_role              (dec_role),
        .dec_possible_dir      (dec_possible_dir),
        .dec_syn_to_west       (dec_syn_to_west),
        .dec_syn_to_east       (dec_syn_to_east),
        .dec_first_aqmeas_flag (dec_first_aqmeas_flag),
        .role                  (role),
        .possible_dir          (possible_dir),
        .syn_to_west           (syn_to_west),
        .syn_to_east           (syn_to_east),
        .first_aqmeas_flag     (first_aqmeas_flag)
    );

endmodule

//--- hdl/educell_region_decoder.sv
`timescale 1ns/1ps
`include "educell_params.svh"

module educell_region_decoder
    import cell_geometry_pkg::*;
(
    input  logic [`LOCATION_BW-1:0] location,
    output region_t                 region,
    output logic                    even
);

    logic west;
    logic north;
    logic east;
    logic south;

    // Bits 1:0 carry distillation info, not decoded here
    assign {even, west, north, east, south} = location[`LOCATION_BW-1 -: 5];

    always_comb
    begin
        if (north && west)
            region = NW;
        else if (north && !east)
            region = N;
        else if (north && east)
            region = NE;
        else if (west && !south)
            region = W;
        else if (east && !south)
            region = E;
        else if (west && south)
            region = SW;
        else if (south && !east)
            region = S;
        else if (south && east)
            region = SE;
        else
            region = C;                     // Interior
    end

endmodule

//--- hdl/educell_role_decoder.sv
`timescale 1ns/1ps
`include "educell_params.svh"

module educell_role_decoder
    import cell_geometry_pkg::*;
    import patch_config_pkg::*;
(
    input  region_t  region,
    input  logic     even,
    input  pchtype_t pchtype,
    input  facebd_t  facebd_e,
    output role_t    role,
    output dir_set_t possible_dir
);

    logic east_mp;
    logic east_pp;

    assign east_mp = (facebd_e == `FACEBD_MP);
    assign east_pp = (facebd_e == `FACEBD_PP);

    // Direction literals read nw, ne, sw, se, n, s
    always_comb
    begin
        role = `ROLE_INACTIVE;              // Also the unsupported result
        possible_dir = '0;
        if (pchtype == `PCHTYPE_ZT)
        begin
            case (region)
                NW: ;                       // Corner stays idle
                N:
                begin
                    role = even ? `ROLE_ACTIVE : `ROLE_BOUNDARY;
                    possible_dir = 6'b001100;
                end
                NE:
                begin
                    role = `ROLE_BOUNDARY;
                    possible_dir = east_mp ? 6'b001100 : 6'b001000;
                end
                W:
                begin
                    role = even ? `ROLE_ACTIVE : `ROLE_BOUNDARY;
                    possible_dir = 6'b010100;
                end
                E:
                begin
                    if (east_mp)
                        role = `ROLE_ACTIVE;
                    else
                        role = even ? `ROLE_BOUNDARY : `ROLE_ACTIVE;
                    possible_dir = east_mp ? 6'b111100 : 6'b101000;
                end
                SW:
                begin
                    role = `ROLE_BOUNDARY;
                    possible_dir = 6'b010100;
                end
                SE:
                begin
                    role = east_mp ? `ROLE_ACTIVE : `ROLE_BOUNDARY;
                    possible_dir = east_mp ? 6'b111001 : 6'b101000;  // Merge reaches south
                end
                default:                    // S and C
                begin
                    role = `ROLE_ACTIVE;
                    possible_dir = 6'b111100;
                end
            endcase
        end
        else if (pchtype == `PCHTYPE_ZB)
        begin
            case (region)
                NW:
                begin
                    role = `ROLE_BOUNDARY;
                    possible_dir = 6'b010100;
                end
                NE:
                begin
                    role = east_pp ? `ROLE_ACTIVE : `ROLE_BOUNDARY;
                    possible_dir = east_pp ? 6'b101110 : 6'b101000;  // Merge reaches north
                end
                W:
                begin
                    role = even ? `ROLE_BOUNDARY : `ROLE_ACTIVE;
                    possible_dir = 6'b010100;
                end
                E:
                begin
                    if (east_pp)
                        role = `ROLE_ACTIVE;
                    else
                        role = even ? `ROLE_ACTIVE : `ROLE_BOUNDARY;
                    possible_dir = east_pp ? 6'b111100 : 6'b101000;
                end
                SW: ;                       // Corner stays idle
                S:
                begin
                    role = even ? `ROLE_BOUNDARY : `ROLE_ACTIVE;
                    possible_dir = 6'b110000;
                end
                SE:
                begin
                    role = `ROLE_BOUNDARY;
                    possible_dir = east_pp ? 6'b110000 : 6'b100000;
                end
                default:                    // N and C
                begin
                    role = `ROLE_ACTIVE;
                    possible_dir = 6'b111100;
                end
            endcase
        end
    end

endmodule

//--- hdl/educell_stabilizer_decoder.sv
`timescale 1ns/1ps
`include "educell_params.svh"

module educell_stabilizer_decoder
    import cell_geometry_pkg::*;
    import patch_config_pkg::*;
(
    input  region_t  region,
    input  logic     even,
    input  pchtype_t pchtype,
    input  facebd_t  facebd_e,
    output pauli_t   syn_to_west,
    output pauli_t   syn_to_east,
    output logic     first_aqmeas_flag
);

    logic east_side;
    logic east_mp;
    logic east_pp;

    assign east_side = (region == NE) || (region == E) || (region == SE);
    assign east_mp = (facebd_e == `FACEBD_MP);
    assign east_pp = (facebd_e == `FACEBD_PP);

    always_comb
    begin
        // Checkerboard by parity unless the ZT east edge overrides
        syn_to_west = even ? `PP_Z : `PP_X;
        syn_to_east = even ? `PP_Z : `PP_X;
        first_aqmeas_flag = 1'b0;
        if (pchtype == `PCHTYPE_ZT)
        begin
            if (region == E)
            begin
                if (east_mp)
                    syn_to_east = even ? `PP_X : `PP_Z;
                else
                    syn_to_east = `PP_I;    // Open edge, nothing sent
            end
            else if (region == SE)
            begin
                syn_to_west = `PP_Z;
                syn_to_east = east_mp ? `PP_X : `PP_I;
            end
            first_aqmeas_flag = east_side && east_mp && even;
        end
        else if (pchtype == `PCHTYPE_ZB)
        begin
            first_aqmeas_flag = east_side && east_pp && !even;
        end
    end

endmodule

//--- hdl/patch_config_pkg.sv
`include "educell_params.svh"

package patch_config_pkg;

    // Patch kind, only ZT and ZB are supported
    typedef logic [`PCHTYPE_BW-1:0] pchtype_t;

    // One face of the patch boundary
    typedef logic [`FACEBD_BW-1:0] facebd_t;

    // Inactive, active or boundary cell
    typedef logic [1:0] role_t;

    // I, X or Z
    typedef logic [1:0] pauli_t;

endpackage

//--- tests/educell_checker.sv
`timescale 1ns/1ps
`include "educell_params.svh"

module educell_checker
    import cell_geometry_pkg::*;
    import patch_config_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        req,
    input  logic        ack,
    input  role_t       role,
    input  dir_set_t    possible_dir,
    input  pauli_t      syn_to_west,
    input  pauli_t      syn_to_east,
    input  logic        first_aqmeas_flag,
    input  logic [12:0] exp_result,
    input  logic [1:0]  test_group,
    input  logic [7:0]  test_index,
    input  logic        report,
    output int          test_count,
    output int          error_count
);

    logic [12:0] actual;
    logic [12:0] held;                              // Last captured results
    logic        prev_ack;
    logic        prev_req;
    logic        reset_checked;

    function automatic string result_text(input logic [12:0] v);
        return $sformatf("role=%0d dir=%06b west=%0d east=%0d flag=%0b",
                         v[12:11], v[10:5], v[4:3], v[2:1], v[0]);
    endfunction

    function automatic string test_name(input logic [1:0] group, input logic [7:0] idx);
        case (group)
            2'd0: return $sformatf("zt_sweep_%0d", idx);
            2'd1: return $sformatf("zb_sweep_%0d", idx);
            2'd2: return $sformatf("unsupported_%0d", idx);
            default: return $sformatf("random_%0d", idx);
        endcase
    endfunction

    assign actual = {role, possible_dir, syn_to_west, syn_to_east, first_aqmeas_flag};

    // Sampled away from the rising edge where the DUT updates
    always @(negedge clk)
    begin
        if (reset)
        begin
            prev_ack = 1'b0;
            prev_req = 1'b0;
            held = '0;
            reset_checked = 1'b0;
            test_count = 0;
            error_count = 0;
        end
        else
        begin
            if (!reset_checked)
            begin
                reset_checked = 1'b1;
                test_count++;
                if (ack !== 1'b0 || actual !== {`ROLE_INACTIVE, 11'd0})
                begin
                    error_count++;
                    $display("mismatch reset_values expected ack=0 %s actual ack=%0b %s",
                             result_text({`ROLE_INACTIVE, 11'd0}), ack, result_text(actual));
                end
                else
                    $display("pass reset_values");
            end
            if (ack && !prev_ack)
            begin
                if (!prev_req)
                begin
                    error_count++;
                    $display("ack rose without a request in %s",
                             test_name(test_group, test_index));
                end
                test_count++;
                if (actual !== exp_result)
                begin
                    error_count++;
                    $display("mismatch %s expected %s actual %s",
                             test_name(test_group, test_index),
                             result_text(exp_result), result_text(actual));
                end
                else
                    $display("pass %s", test_name(test_group, test_index));
                held = actual;
            end
            else if (actual !== held)
            begin
                error_count++;
                $display("results changed without a capture after %s",
                         test_name(test_group, test_index));
            end
            if (!ack && prev_ack && prev_req)
            begin
                error_count++;
                $display("ack fell while req was still high in %s",
                         test_name(test_group, test_index));
            end
            prev_ack = ack;
            prev_req = req;
        end
    end

    always @(posedge report)
        $display("tests checked %0d, errors %0d", test_count, error_count);

endmodule

//--- tests/tb_educell_predecoder.sv
`timescale 1ns/1ps
`include "educell_params.svh"

module tb_educell_predecoder
    import cell_geometry_pkg::*;
    import patch_config_pkg::*;
();

    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYCLES = 16;
    localparam int SWEEP_TESTS = 36;                // 2 east faces x 9 regions x 2 parities
    localparam int UNSUPPORTED_TESTS = 28;
    localparam int RANDOM_TESTS = 200;
    localparam int TOTAL_TESTS = 1 + 2 * SWEEP_TESTS + UNSUPPORTED_TESTS + RANDOM_TESTS;
    localparam int TIMEOUT_CYCLES = TOTAL_TESTS * 8 + RESET_CYCLES + 100;

    // One bit per direction
    localparam dir_set_t D_NONE = 6'b000000;
    localparam dir_set_t D_NW = 6'b100000;
    localparam dir_set_t D_NE = 6'b010000;
    localparam dir_set_t D_SW = 6'b001000;
    localparam dir_set_t D_SE = 6'b000100;
    localparam dir_set_t D_N = 6'b000010;
    localparam dir_set_t D_S = 6'b000001;
    localparam dir_set_t D_ALL4 = D_NW | D_NE | D_SW | D_SE;

    logic                    clk;
    logic                    reset;
    logic [`LOCATION_BW-1:0] location;
    logic [`PCHINFO_BW-1:0]  pchinfo;
    logic                    req;
    logic                    ack;
    role_t                   role;
    dir_set_t                possible_dir;
    pauli_t                  syn_to_west;
    pauli_t                  syn_to_east;
    logic                    first_aqmeas_flag;
    logic [12:0]             exp_result;
    logic [1:0]              test_group;
    logic [7:0]              test_index;
    logic                    report;
    int                      test_count;
    int                      error_count;
    logic [31:0]             lcg_state;

    educell_predecoder educell_predecoder_inst
    (
        .clk               (clk),
        .reset             (reset),
        .location          (location),
        .pchinfo           (pchinfo),
        .req               (req),
        .ack               (ack),
        .role              (role),
        .possible_dir      (possible_dir),
        .syn_to_west       (syn_to_west),
        .syn_to_east       (syn_to_east),
        .first_aqmeas_flag (first_aqmeas_flag)
    );

    educell_checker checker_inst
    (
        .clk               (clk),
        .reset             (reset),
        .req               (req),
        .ack               (ack),
        .role              (role),
        .possible_dir      (possible_dir),
        .syn_to_west       (syn_to_west),
        .syn_to_east       (syn_to_east),
        .first_aqmeas_flag (first_aqmeas_flag),
        .exp_result        (exp_result),
        .test_group        (test_group),
        .test_index        (test_index),
        .report            (report),
        .test_count        (test_count),
        .error_count       (error_count)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Packed as {role, dir, west, east, flag}
    function automatic logic [12:0] expected_result(input logic [`LOCATION_BW-1:0] loc,
                                                    input logic [`PCHINFO_BW-1:0] info);
        logic     even;
        logic     west;
        logic     north;
        logic     east;
        logic     south;
        region_t  rg;
        pchtype_t pt;
        logic     mp;
        logic     pp;
        logic     east_side;
        role_t    rl;
        dir_set_t dir;
        pauli_t   syn_w;
        pauli_t   syn_e;
        logic     flag;

        {even, west, north, east, south} = loc[6:2];
        pt = info[11:8];
        mp = (info[3:2] == `FACEBD_MP);
        pp = (info[3:2] == `FACEBD_PP);
        if (north && west)
            rg = NW;
        else if (north)
            rg = east ? NE : N;
        else if (west && !south)
            rg = W;
        else if (east && !south)
            rg = E;
        else if (west)
            rg = SW;
        else if (south)
            rg = east ? SE : S;
        else
            rg = C;

        {rl, dir} = {`ROLE_INACTIVE, D_NONE};
        if (pt == `PCHTYPE_ZT)
        begin
            case (rg)
                NW: {rl, dir} = {`ROLE_INACTIVE, D_NONE};
                N:  {rl, dir} = {even ? `ROLE_ACTIVE : `ROLE_BOUNDARY, D_SW | D_SE};
                NE: {rl, dir} = {`ROLE_BOUNDARY, mp ? (D_SW | D_SE) : D_SW};
                W:  {rl, dir} = {even ? `ROLE_ACTIVE : `ROLE_BOUNDARY, D_NE | D_SE};
                E:  {rl, dir} = mp ? {`ROLE_ACTIVE, D_ALL4}
                                   : {even ? `ROLE_BOUNDARY : `ROLE_ACTIVE, D_NW | D_SW};
                SW: {rl, dir} = {`ROLE_BOUNDARY, D_NE | D_SE};
                S:  {rl, dir} = {`ROLE_ACTIVE, D_ALL4};
                SE: {rl, dir} = mp ? {`ROLE_ACTIVE, D_NW | D_NE | D_SW | D_S}
                                   : {`ROLE_BOUNDARY, D_NW | D_SW};
                default: {rl, dir} = {`ROLE_ACTIVE, D_ALL4};
            endcase
        end
        else if (pt == `PCHTYPE_ZB)
        begin
            case (rg)
                NW: {rl, dir} = {`ROLE_BOUNDARY, D_NE | D_SE};
                N:  {rl, dir} = {`ROLE_ACTIVE, D_ALL4};
                NE: {rl, dir} = pp ? {`ROLE_ACTIVE, D_NW | D_SW | D_SE | D_N}
                                   : {`ROLE_BOUNDARY, D_NW | D_SW};
                W:  {rl, dir} = {even ? `ROLE_BOUNDARY : `ROLE_ACTIVE, D_NE | D_SE};
                E:  {rl, dir} = pp ? {`ROLE_ACTIVE, D_ALL4}
                                   : {even ? `ROLE_ACTIVE : `ROLE_BOUNDARY, D_NW | D_SW};
                SW: {rl, dir} = {`ROLE_INACTIVE, D_NONE};
                S:  {rl, dir} = {even ? `ROLE_BOUNDARY : `ROLE_ACTIVE, D_NW | D_NE};
                SE: {rl, dir} = {`ROLE_BOUNDARY, pp ? (D_NW | D_NE) : D_NW};
                default: {rl, dir} = {`ROLE_ACTIVE, D_ALL4};
            endcase
        end

        {syn_w, syn_e} = even ? {`PP_Z, `PP_Z} : {`PP_X, `PP_X};
        if (pt == `PCHTYPE_ZT && rg == E)
            {syn_w, syn_e} = mp ? (even ? {`PP_Z, `PP_X} : {`PP_X, `PP_Z})
                                : (even ? {`PP_Z, `PP_I} : {`PP_X, `PP_I});
        else if (pt == `PCHTYPE_ZT && rg == SE)
            {syn_w, syn_e} = mp ? {`PP_Z, `PP_X} : {`PP_Z, `PP_I};

        east_side = (rg == NE) || (rg == E) || (rg == SE);
        flag = (pt == `PCHTYPE_ZT && east_side && mp && even)
            || (pt == `PCHTYPE_ZB && east_side && pp && !even);
        return {rl, dir, syn_w, syn_e, flag};
    endfunction

    function automatic logic [`LOCATION_BW-1:0] region_location(input region_t rg,
                                                                input logic even,
                                                                input logic [1:0] low);
        logic [3:0] wnes;

        case (rg)
            NW: wnes = 4'b1100;
            N:  wnes = 4'b0100;
            NE: wnes = 4'b0110;
            W:  wnes = 4'b1000;
            E:  wnes = 4'b0010;
            SW: wnes = 4'b1001;
            S:  wnes = 4'b0001;
            SE: wnes = 4'b0011;
            default: wnes = 4'b0000;
        endcase
        return {even, wnes, low};                   // Low bits are don't care
    endfunction

    // Full four-phase handshake for one configuration
    task automatic run_one(input logic [`LOCATION_BW-1:0] loc, input logic [`PCHINFO_BW-1:0] info,
                           input logic [1:0] group, input logic [7:0] idx);
        @(posedge clk);
        location <= loc;
        pchinfo <= info;
        exp_result <= expected_result(loc, info);
        test_group <= group;
        test_index <= idx;
        req <= 1'b1;
        do @(negedge clk); while (ack !== 1'b1);
        @(posedge clk);
        req <= 1'b0;
        do @(negedge clk); while (ack !== 1'b0);
    endtask

    task automatic sweep(input pchtype_t pt, input facebd_t fe_a, input facebd_t fe_b,
                         input logic [1:0] group);
        int      idx;
        int      f;
        int      r;
        int      ev;
        facebd_t fe;

        idx = 0;
        for (f = 0; f < 2; f++)
            for (r = 0; r < 9; r++)
                for (ev = 0; ev < 2; ev++)
                begin
                    fe = (f == 0) ? fe_a : fe_b;
                    run_one(region_location(region_t'(r), ev[0], idx[1:0]),
                            {pt, idx[1:0], idx[2:1], fe, idx[3:2]}, group, idx[7:0]);
                    idx++;
                end
    endtask

    task automatic unsupported_types();
        int idx;
        int t;

        idx = 0;
        for (t = 0; t < 16; t++)
        begin
            if (t[3:0] != `PCHTYPE_ZT && t[3:0] != `PCHTYPE_ZB)
            begin
                run_one(region_location(E, 1'b1, 2'b01),    // Flag case for ZT
                        {t[3:0], `FACEBD_LP, `FACEBD_PP, `FACEBD_MP, `FACEBD_NONE},
                        2'd2, idx[7:0]);
                run_one(region_location(SE, 1'b0, 2'b11),   // Flag case for ZB
                        {t[3:0], `FACEBD_MP, `FACEBD_LP, `FACEBD_PP, `FACEBD_MP},
                        2'd2, idx[7:0] + 8'd1);
                idx += 2;
            end
        end
    endtask

    task automatic random_loads();
        int                      i;
        logic [`LOCATION_BW-1:0] loc;
        logic [`PCHINFO_BW-1:0]  info;

        for (i = 0; i < RANDOM_TESTS; i++)
        begin
            lcg_state = lcg_next(lcg_state);
            loc = lcg_state[22:16];
            lcg_state = lcg_next(lcg_state);
            info = lcg_state[27:16];
            if (lcg_state[31:30] == 2'd0)
                info[11:8] = `PCHTYPE_ZT;
            else if (lcg_state[31:30] == 2'd1)
                info[11:8] = `PCHTYPE_ZB;
            run_one(loc, info, 2'd3, i[7:0]);
        end
    endtask

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, a handshake never completed",
                 TIMEOUT_CYCLES);
        $display("sim failed");
        $finish;
    end

    initial
    begin
        reset = 1'b1;
        req = 1'b0;
        location = '0;
        pchinfo = '0;
        exp_result = '0;
        test_group = 2'd0;
        test_index = 8'd0;
        report = 1'b0;
        lcg_state = 32'd38;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        sweep(`PCHTYPE_ZT, `FACEBD_MP, `FACEBD_PP, 2'd0);
        sweep(`PCHTYPE_ZB, `FACEBD_PP, `FACEBD_LP, 2'd1);
        unsupported_types();
        random_loads();
        @(posedge clk);
        report <= 1'b1;                             // Checker prints the counts
        @(posedge clk);
        if (error_count == 0 && test_count == TOTAL_TESTS)
            $display("sim passed");
        else
        begin
            if (test_count != TOTAL_TESTS)
                $display("expected %0d tests but %0d were checked", TOTAL_TESTS, test_count);
            $display("sim failed");
        end
        $finish;
    end

endmodule
